//--- common/gomoku_pkg.sv
`default_nettype none

package gomoku_pkg;

    // Board geometry
    localparam int BOARD_DIM   = 15;
    localparam int NUM_CELLS   = BOARD_DIM * BOARD_DIM;
    localparam int SCAN_CYCLES = BOARD_DIM;              // One column per cycle
    localparam int COL_W       = $clog2(SCAN_CYCLES);

    typedef logic [1:0] cell_t;

    localparam cell_t CELL_BLACK = 2'd0;
    localparam cell_t CELL_WHITE = 2'd1;
    localparam cell_t CELL_EMPTY = 2'd2;                 // Code 3 matches nothing

    // Row 0 at the low end of a column
    typedef cell_t [BOARD_DIM-1:0] line_t;

    // Cell k at bits 2k+1..2k, k = row * BOARD_DIM + col
    typedef cell_t [NUM_CELLS-1:0] board_t;

    typedef logic [COL_W-1:0] col_t;

    // Window length of each shape
    localparam int WIN_FIVE         = 5;
    localparam int WIN_OPEN_FOUR    = 6;
    localparam int WIN_BLOCKED_FOUR = 6;
    localparam int WIN_OPEN_THREE   = 5;
    localparam int WIN_OPEN_TWO     = 6;
    localparam int WIN_SINGLE       = 3;

    typedef logic [23:0] weight_t;

    localparam weight_t W_FIVE         = 24'd1000000;
    localparam weight_t W_OPEN_FOUR    = 24'd100000;
    localparam weight_t W_BLOCKED_FOUR = 24'd10000;
    localparam weight_t W_OPEN_THREE   = 24'd1000;
    localparam weight_t W_OPEN_TWO     = 24'd100;
    localparam weight_t W_SINGLE       = 24'd10;

    // At most 13 windows per column
    typedef logic [3:0] count_t;

    typedef logic signed [31:0] score_t;

endpackage

`default_nettype wire

//--- common/pattern_count_if.sv
`default_nettype none

interface pattern_count_if;

    gomoku_pkg::count_t five;
    gomoku_pkg::count_t open_four;
    gomoku_pkg::count_t blocked_four;
    gomoku_pkg::count_t open_three;
    gomoku_pkg::count_t open_two;
    gomoku_pkg::count_t single;

    modport producer (
        output five, open_four, blocked_four, open_three, open_two, single
    );

    modport consumer (
        input five, open_four, blocked_four, open_three, open_two, single
    );

endinterface

`default_nettype wire

//--- src/column_scanner.sv
`default_nettype none

module column_scanner (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_start,
    input  wire gomoku_pkg::board_t    i_board,
    output gomoku_pkg::line_t          o_line,
    output logic                       o_line_valid,
    output logic                       o_clear,
    output logic                       o_last
);

    logic               busy_r, busy_w;
    gomoku_pkg::col_t   col_r, col_w;
    logic               last_col;

    assign last_col = (col_r == gomoku_pkg::col_t'(gomoku_pkg::SCAN_CYCLES - 1));

    assign o_clear      = i_start && !busy_r;      // Start ignored while busy
    assign o_line_valid = busy_r;
    assign o_last       = busy_r && last_col;

    // Column select, one row every BOARD_DIM cells
    always_comb begin
        for (int r = 0; r < gomoku_pkg::BOARD_DIM; r++) begin
            o_line[r] = i_board[r * gomoku_pkg::BOARD_DIM + int'(col_r)];
        end
    end

    always_comb begin
        busy_w = busy_r;
        col_w  = col_r;

        if (o_clear) begin
            busy_w = 1'b1;
            col_w  = '0;
        end
        else if (busy_r) begin
            if (last_col) begin
                busy_w = 1'b0;                      // Column 14 done
            end
            else begin
                col_w = col_r + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            busy_r <= 1'b0;
            col_r  <= '0;
        end
        else begin
            busy_r <= busy_w;
            col_r  <= col_w;
        end
    end

endmodule

`default_nettype wire

//--- src/line_matcher.sv
`default_nettype none

module line_matcher #(
    parameter gomoku_pkg::cell_t OWN = gomoku_pkg::CELL_BLACK
) (
    input  wire gomoku_pkg::line_t  i_line,
    pattern_count_if.producer       o_counts
);

    localparam gomoku_pkg::cell_t OPP =
        (OWN == gomoku_pkg::CELL_BLACK) ? gomoku_pkg::CELL_WHITE : gomoku_pkg::CELL_BLACK;

    localparam int DIM = gomoku_pkg::BOARD_DIM;

    logic [DIM-1:0] own_row;
    logic [DIM-1:0] opp_row;
    logic [DIM-1:0] emp_row;

    gomoku_pkg::count_t n_five;
    gomoku_pkg::count_t n_open_four;
    gomoku_pkg::count_t n_blocked_four;
    gomoku_pkg::count_t n_open_three;
    gomoku_pkg::count_t n_open_two;
    gomoku_pkg::count_t n_single;

    // Per-row cell class, code 3 falls in none
    always_comb begin
        for (int r = 0; r < DIM; r++) begin
            own_row[r] = (i_line[r] == OWN);
            opp_row[r] = (i_line[r] == OPP);
            emp_row[r] = (i_line[r] == gomoku_pkg::CELL_EMPTY);
        end
    end

    // Each window start row counts once, overlaps included
    always_comb begin
        n_five         = '0;
        n_open_four    = '0;
        n_blocked_four = '0;
        n_open_three   = '0;
        n_open_two     = '0;
        n_single       = '0;

        for (int s = 0; s <= DIM - gomoku_pkg::WIN_FIVE; s++) begin
            if (&own_row[s +: gomoku_pkg::WIN_FIVE]) begin
                n_five = n_five + 1'b1;
            end
        end

        for (int s = 0; s <= DIM - gomoku_pkg::WIN_OPEN_FOUR; s++) begin
            if (emp_row[s] && (&own_row[s+1 +: 4]) && emp_row[s+5]) begin
                n_open_four = n_open_four + 1'b1;
            end
        end

        // Blocked on either end by the opponent, never by the edge
        for (int s = 0; s <= DIM - gomoku_pkg::WIN_BLOCKED_FOUR; s++) begin
            if ((&own_row[s+1 +: 4]) &&
                ((emp_row[s] && opp_row[s+5]) || (opp_row[s] && emp_row[s+5]))) begin
                n_blocked_four = n_blocked_four + 1'b1;
            end
        end

        for (int s = 0; s <= DIM - gomoku_pkg::WIN_OPEN_THREE; s++) begin
            if (emp_row[s] && (&own_row[s+1 +: 3]) && emp_row[s+4]) begin
                n_open_three = n_open_three + 1'b1;
            end
        end

        for (int s = 0; s <= DIM - gomoku_pkg::WIN_OPEN_TWO; s++) begin
            if ((&emp_row[s +: 2]) && (&own_row[s+2 +: 2]) && (&emp_row[s+4 +: 2])) begin
                n_open_two = n_open_two + 1'b1;
            end
        end

        for (int s = 0; s <= DIM - gomoku_pkg::WIN_SINGLE; s++) begin
            if (emp_row[s] && own_row[s+1] && emp_row[s+2]) begin
                n_single = n_single + 1'b1;
            end
        end
    end

    assign o_counts.five         = n_five;
    assign o_counts.open_four    = n_open_four;
    assign o_counts.blocked_four = n_blocked_four;
    assign o_counts.open_three   = n_open_three;
    assign o_counts.open_two     = n_open_two;
    assign o_counts.single       = n_single;

endmodule

`default_nettype wire

//--- src/score_accum.sv
`default_nettype none

module score_accum (
    input  wire logic           i_clk,
    input  wire logic           i_rst_n,
    input  wire logic           i_line_valid,
    input  wire logic           i_clear,
    input  wire logic           i_last,
    pattern_count_if.consumer   i_black,
    pattern_count_if.consumer   i_white,
    output gomoku_pkg::score_t  o_score,
    output logic                o_finish
);

    gomoku_pkg::score_t black_tot_r, black_tot_w;
    gomoku_pkg::score_t white_tot_r, white_tot_w;
    gomoku_pkg::score_t score_r, score_w;
    logic               finish_r, finish_w;

    gomoku_pkg::score_t black_add;
    gomoku_pkg::score_t white_add;

    function automatic gomoku_pkg::score_t weigh(input gomoku_pkg::count_t n,
                                                 input gomoku_pkg::weight_t w);
        weigh = gomoku_pkg::score_t'(n) * gomoku_pkg::score_t'(w);
    endfunction

    // Weighted sum of one column
    assign black_add = weigh(i_black.five,         gomoku_pkg::W_FIVE)
                     + weigh(i_black.open_four,    gomoku_pkg::W_OPEN_FOUR)
                     + weigh(i_black.blocked_four, gomoku_pkg::W_BLOCKED_FOUR)
                     + weigh(i_black.open_three,   gomoku_pkg::W_OPEN_THREE)
                     + weigh(i_black.open_two,     gomoku_pkg::W_OPEN_TWO)
                     + weigh(i_black.single,       gomoku_pkg::W_SINGLE);

    assign white_add = weigh(i_white.five,         gomoku_pkg::W_FIVE)
                     + weigh(i_white.open_four,    gomoku_pkg::W_OPEN_FOUR)
                     + weigh(i_white.blocked_four, gomoku_pkg::W_BLOCKED_FOUR)
                     + weigh(i_white.open_three,   gomoku_pkg::W_OPEN_THREE)
                     + weigh(i_white.open_two,     gomoku_pkg::W_OPEN_TWO)
                     + weigh(i_white.single,       gomoku_pkg::W_SINGLE);

    assign o_score  = score_r;
    assign o_finish = finish_r;

    always_comb begin
        black_tot_w = black_tot_r;
        white_tot_w = white_tot_r;
        score_w     = score_r;
        finish_w    = finish_r;

        if (i_clear) begin
            black_tot_w = '0;
            white_tot_w = '0;
            finish_w    = 1'b0;
        end
        else if (i_line_valid) begin
            black_tot_w = black_tot_r + black_add;
            white_tot_w = white_tot_r + white_add;
            if (i_last) begin
                score_w  = black_tot_w - white_tot_w;   // Includes column 14
                finish_w = 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            black_tot_r <= '0;
            white_tot_r <= '0;
            score_r     <= '0;
            finish_r    <= 1'b0;
        end
        else begin
            black_tot_r <= black_tot_w;
            white_tot_r <= white_tot_w;
            score_r     <= score_w;
            finish_r    <= finish_w;
        end
    end

endmodule

`default_nettype wire

//--- src/gomoku_score_top.sv
`default_nettype none

module gomoku_score_top (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire logic                  i_start,
    input  wire gomoku_pkg::board_t    i_board,
    output gomoku_pkg::score_t         o_score,
    output logic                       o_finish
);

    gomoku_pkg::line_t  line;
    logic               line_valid;
    logic               clear;
    logic               last;

    pattern_count_if black_counts ();
    pattern_count_if white_counts ();

    column_scanner u_scanner (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_start      (i_start),
        .i_board      (i_board),
        .o_line       (line),
        .o_line_valid (line_valid),
        .o_clear      (clear),
        .o_last       (last)
    );

    line_matcher #(.OWN(gomoku_pkg::CELL_BLACK)) u_match_black (
        .i_line   (line),
        .o_counts (black_counts)
    );

    line_matcher #(.OWN(gomoku_pkg::CELL_WHITE)) u_match_white (
        .i_line   (line),
        .o_counts (white_counts)
    );

    score_accum u_accum (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_line_valid (line_valid),
        .i_clear      (clear),
        .i_last       (last),
        .i_black      (black_counts),
        .i_white      (white_counts),
        .o_score      (o_score),
        .o_finish     (o_finish)
    );

endmodule

`default_nettype wire

//--- bench/gomoku_score_props.sv
`default_nettype none

module gomoku_score_props (
    input wire logic                i_clk,
    input wire logic                i_rst_n,
    input wire logic                i_clear,
    input wire logic                i_finish,
    input wire gomoku_pkg::score_t  i_score
);

    logic [4:0] since_clear;   // Edges since the accepted start, holds at 16

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            since_clear <= '0;
        end
        else if (i_clear) begin
            since_clear <= 5'd1;
        end
        else if (since_clear != 5'd0 && since_clear < 5'd16) begin
            since_clear <= since_clear + 1'b1;
        end
    end

    finish_low_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (since_clear != 5'd0 && since_clear <= 5'd15) |-> !i_finish)
        else $error("finish went high before all 15 columns were summed");

    finish_rise_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (since_clear == 5'd15) |=> i_finish)
        else $error("finish did not go high after column 14");

    score_hold_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_finish && $past(i_finish)) |-> $stable(i_score))
        else $error("score changed while finish stayed high");

    score_update_a: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $changed(i_score) |-> (i_finish && !$past(i_finish)))
        else $error("score changed outside the end of a scan");

endmodule

bind score_accum gomoku_score_props u_props (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_clear  (i_clear),
    .i_finish (o_finish),
    .i_score  (o_score)
);

`default_nettype wire

//--- bench/tb_gomoku_score.sv
`default_nettype none

module tb_gomoku_score;

    localparam int DIM        = gomoku_pkg::BOARD_DIM;
    localparam int MAX_CYCLES = 6000;   // About 230 runs of about 20 cycles, with margin

    logic                clk;
    logic                rst_n;
    logic                start;
    gomoku_pkg::board_t  board;
    gomoku_pkg::score_t  score;
    logic                finish;

    int seed;
    int cycles = 0;
    int checks = 0;
    int mismatches = 0;
    int failures = 0;

    gomoku_score_top u_dut (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_start  (start),
        .i_board  (board),
        .o_score  (score),
        .o_finish (finish)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", MAX_CYCLES);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic int pick(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic gomoku_pkg::cell_t cell_of(input gomoku_pkg::board_t b,
                                                  input int row, input int col);
        return b[row * DIM + col];
    endfunction

    // True when len cells from row downward all hold code
    function automatic bit run_is(input gomoku_pkg::board_t b, input int col, input int row,
                                  input int len, input gomoku_pkg::cell_t code);
        for (int i = 0; i < len; i++) begin
            if (cell_of(b, row + i, col) != code) return 1'b0;
        end
        return 1'b1;
    endfunction

    // Weighted shape sum of one column for one colour
    function automatic int line_value(input gomoku_pkg::board_t b, input int col,
                                      input gomoku_pkg::cell_t own);
        gomoku_pkg::cell_t opp;
        gomoku_pkg::cell_t lo;
        gomoku_pkg::cell_t hi;
        gomoku_pkg::cell_t em;
        bit                four;
        int                sum;
        em   = gomoku_pkg::CELL_EMPTY;
        opp  = (own == gomoku_pkg::CELL_BLACK) ? gomoku_pkg::CELL_WHITE : gomoku_pkg::CELL_BLACK;
        sum  = 0;
        for (int s = 0; s < DIM; s++) begin
            if (s + 3 <= DIM) begin
                if (cell_of(b, s, col) == em && cell_of(b, s + 1, col) == own &&
                    cell_of(b, s + 2, col) == em) sum += int'(gomoku_pkg::W_SINGLE);
            end
            if (s + 5 <= DIM) begin
                if (run_is(b, col, s, 5, own)) sum += int'(gomoku_pkg::W_FIVE);
                if (cell_of(b, s, col) == em && run_is(b, col, s + 1, 3, own) &&
                    cell_of(b, s + 4, col) == em) sum += int'(gomoku_pkg::W_OPEN_THREE);
            end
            if (s + 6 <= DIM) begin
                four = run_is(b, col, s + 1, 4, own);
                lo   = cell_of(b, s, col);
                hi   = cell_of(b, s + 5, col);
                if (four && lo == em && hi == em) sum += int'(gomoku_pkg::W_OPEN_FOUR);
                if (four && ((lo == em && hi == opp) || (lo == opp && hi == em)))
                    sum += int'(gomoku_pkg::W_BLOCKED_FOUR);
                if (run_is(b, col, s, 2, em) && run_is(b, col, s + 2, 2, own) &&
                    run_is(b, col, s + 4, 2, em)) sum += int'(gomoku_pkg::W_OPEN_TWO);
            end
        end
        return sum;
    endfunction

    function automatic int model_score(input gomoku_pkg::board_t b);
        int total;
        total = 0;
        for (int c = 0; c < DIM; c++) begin
            total += line_value(b, c, gomoku_pkg::CELL_BLACK);
            total -= line_value(b, c, gomoku_pkg::CELL_WHITE);
        end
        return total;
    endfunction

    function automatic string shape_name(input int shape);
        case (shape)
            0:       return "five";
            1:       return "open four";
            2:       return "blocked four";
            3:       return "edge four";
            4:       return "open three";
            5:       return "open two";
            default: return "single";
        endcase
    endfunction

    // One shape along line 7 on an empty board, down column 7 or across row 7
    function automatic gomoku_pkg::board_t shape_board(input int shape,
                                                       input gomoku_pkg::cell_t own,
                                                       input bit horiz);
        gomoku_pkg::board_t b;
        int                 first;
        int                 len;
        int                 pos;
        first = 3;
        len   = 4;
        for (int k = 0; k < gomoku_pkg::NUM_CELLS; k++) b[k] = gomoku_pkg::CELL_EMPTY;
        case (shape)
            0: len = 5;
            3: first = 0;                                // Touches the board edge
            4: len = 3;
            5: len = 2;
            6: begin
                first = 5;
                len   = 1;
            end
            default: len = 4;
        endcase
        for (int i = 0; i <= len; i++) begin
            pos = first + i;
            if (i < len) begin
                b[horiz ? 7 * DIM + pos : pos * DIM + 7] = own;
            end
            else if (shape == 2) begin
                b[horiz ? 7 * DIM + pos : pos * DIM + 7] =
                    (own == gomoku_pkg::CELL_BLACK) ? gomoku_pkg::CELL_WHITE : gomoku_pkg::CELL_BLACK;
            end
        end
        return b;
    endfunction

    task automatic make_random_board(output gomoku_pkg::board_t b, input bit biased);
        int                col;
        int                row;
        int                len;
        int                v;
        gomoku_pkg::cell_t code;
        for (int k = 0; k < gomoku_pkg::NUM_CELLS; k++) begin
            v = pick(biased ? 4 : 3);
            b[k] = (v == 0) ? gomoku_pkg::CELL_BLACK :
                   (v == 1) ? gomoku_pkg::CELL_WHITE : gomoku_pkg::CELL_EMPTY;
        end
        if (biased) begin
            for (int r = 0; r < 3; r++) begin                // Long vertical runs
                col  = pick(DIM);
                row  = pick(DIM - 4);
                len  = 4 + pick(3);
                code = pick(2) ? gomoku_pkg::CELL_WHITE : gomoku_pkg::CELL_BLACK;
                for (int i = 0; i < len && row + i < DIM; i++) b[(row + i) * DIM + col] = code;
            end
        end
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        checks++;
        assert (expected == actual) else begin
            mismatches++;
            $display("MISMATCH %s: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    // restart_edge > 0 pulses start again while the scan runs
    task automatic run_eval(input string name, input gomoku_pkg::board_t b,
                            input int restart_edge);
        int expected;
        int edges;
        expected = model_score(b);
        @(posedge clk);
        board <= b;
        start <= 1'b1;
        @(posedge clk);                                  // Edge 0
        start <= 1'b0;
        edges = 0;
        @(negedge clk);
        checks++;
        assert (!finish) else begin
            failures++;
            $display("%s: finish stayed high after the start was accepted", name);
        end
        while (!finish && edges < 40) begin
            @(posedge clk);
            edges++;
            start <= (edges == restart_edge);
            @(negedge clk);
        end
        checks++;
        assert (finish) else begin
            failures++;
            $display("%s: finish never went high", name);
        end
        check_value({name, " finish edge"}, 15, edges);
        check_value({name, " score"}, expected, score);
    endtask

    // Score of the last evaluation must hold while the board changes
    task automatic check_hold(input int held);
        gomoku_pkg::board_t other;
        for (int i = 0; i < 20; i++) begin
            make_random_board(other, 1'b0);
            @(posedge clk);
            board <= other;
            @(negedge clk);
            checks++;
            assert (finish) else begin
                failures++;
                $display("hold: finish dropped without a start");
            end
            check_value("hold score", held, score);
        end
    endtask

    initial begin
        gomoku_pkg::board_t b;
        seed  = 32'h30625653;
        rst_n = 1'b0;
        start = 1'b0;
        board = shape_board(6, gomoku_pkg::CELL_EMPTY, 1'b0);
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        checks++;
        assert (!finish) else begin
            failures++;
            $display("reset: finish is high after reset");
        end
        check_value("reset score", 0, score);

        for (int k = 0; k < 7; k++) begin
            run_eval({"vertical black ", shape_name(k)},
                     shape_board(k, gomoku_pkg::CELL_BLACK, 1'b0), 0);
            run_eval({"vertical white ", shape_name(k)},
                     shape_board(k, gomoku_pkg::CELL_WHITE, 1'b0), 0);
            run_eval({"horizontal black ", shape_name(k)},
                     shape_board(k, gomoku_pkg::CELL_BLACK, 1'b1), 0);
        end
        b = shape_board(1, gomoku_pkg::CELL_WHITE, 1'b0);
        run_eval("restart while busy", b, 5);
        check_hold(model_score(b));

        for (int n = 0; n < 200; n++) begin
            make_random_board(b, n[0]);
            run_eval($sformatf("random %0d", n), b, 0);
        end

        $display("Summary: %0d checks, %0d mismatches, %0d other failures",
                 checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Regression passed");
        end
        else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
common/gomoku_pkg.sv
common/pattern_count_if.sv
src/column_scanner.sv
src/line_matcher.sv
src/score_accum.sv
src/gomoku_score_top.sv
bench/gomoku_score_props.sv
bench/tb_gomoku_score.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module tb_gomoku_score -Mdir obj_dir -f compile.f \
    && ./obj_dir/Vtb_gomoku_score | tee /dev/stderr | grep -q "^Regression passed$" \
    && echo "run_sim: simulation PASS" && exit 0 \
    || { echo "run_sim: simulation FAIL"; exit 1; }
